/* common/isaPkg.sv */
// ISA of the 16-bit core with its word types, field positions and opcodes
// The PC is a byte address and steps by 2 for each 16-bit instruction
// Opcode values not named in opcode_e are illegal and run as NOP
`default_nettype none

package isaPkg;

   localparam int WORD_W = 16;
   localparam int REG_W  = 3;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [REG_W-1:0]  regIdx_t;

   // Field positions, shared by all formats where they overlap
   localparam int OPC_LSB  = 11;
   localparam int OPC_W    = 5;
   localparam int RS_LSB   = 8;
   localparam int RT_LSB   = 5;
   localparam int RD_R_LSB = 2;
   localparam int RD_I_LSB = 5;
   localparam int FN_LSB   = 0;
   localparam int FN_W     = 2;
   localparam int IMM5_W   = 5;
   localparam int IMM8_W   = 8;
   localparam int DISP11_W = 11;

   // JAL links here
   localparam regIdx_t LINK_REG = 3'd7;

   typedef enum logic [OPC_W-1:0] {
      OP_HALT  = 5'b00000,
      OP_NOP   = 5'b00001,
      OP_J     = 5'b00100,
      OP_JR    = 5'b00101,
      OP_JAL   = 5'b00110,
      OP_ADDI  = 5'b01000,
      OP_SUBI  = 5'b01001,
      OP_XORI  = 5'b01010,
      OP_ANDNI = 5'b01011,
      OP_BEQZ  = 5'b01100,
      OP_BNEZ  = 5'b01101,
      OP_BLTZ  = 5'b01110,
      OP_BGEZ  = 5'b01111,
      OP_ST    = 5'b10000,
      OP_LD    = 5'b10001,
      OP_LBI   = 5'b11000,
      OP_ALU   = 5'b11011
   } opcode_e;

   // Funct field of the register ALU format
   typedef enum logic [FN_W-1:0] {
      FN_ADD  = 2'b00,
      FN_SUB  = 2'b01,
      FN_XOR  = 2'b10,
      FN_ANDN = 2'b11
   } aluFunct_e;

endpackage

`default_nettype wire

/* common/ctrlPkg.sv */
// Decoded controls passed from decode to the later stages
// The register write enable in ctrl_t is already gated while halted
`default_nettype none

package ctrlPkg;

   typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_XOR, ALU_ANDN, ALU_PASSB} aluOp_e;

   typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC2} wbSel_e;

   typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP, PC_REG} pcSel_e;

   typedef enum logic [2:0] {BR_NONE, BR_EQZ, BR_NEZ, BR_LTZ, BR_GEZ} brCond_e;

   typedef struct packed {
      aluOp_e  aluOp;
      logic    useImm;
      wbSel_e  wbSel;
      logic    regWe;
      logic    memWe;
      logic    memRe;
      pcSel_e  pcSel;
      brCond_e brCond;
      logic    halt;
      logic    illegal;
   } ctrl_t;

   typedef struct packed {
      ctrl_t           ctrl;
      isaPkg::word_t   rsVal;
      isaPkg::word_t   rtVal;
      isaPkg::word_t   imm;
      isaPkg::regIdx_t rd;
   } decoded_t;

endpackage

`default_nettype wire

/* rtl/fetch.sv */
// PC register, instruction memory and halt latch
// progAddr is a word index; the PC indexes memory with bit 0 dropped
// The load port writes at any time, normally during reset
`timescale 1ns/1ps
`default_nettype none

module fetch #(
   parameter int IMEM_WORDS = 256
) (
   input  logic          clk,
   input  logic          arstN,
   input  logic          progWe,
   input  isaPkg::word_t progAddr,
   input  isaPkg::word_t progData,
   input  isaPkg::word_t nextPc,
   input  logic          haltReq,
   output isaPkg::word_t pc,
   output isaPkg::word_t pcPlus2,
   output isaPkg::word_t instr,
   output logic          halt
);
   import isaPkg::*;

   localparam int IAW = $clog2(IMEM_WORDS);

   word_t imem [IMEM_WORDS];

   always_ff @(posedge clk) begin
      if (progWe) begin
         imem[progAddr[IAW-1:0]] <= progData;
      end
   end

   assign instr   = imem[pc[IAW:1]];
   assign pcPlus2 = pc + word_t'(2);

   // PC stays on the HALT instruction
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pc   <= '0;
         halt <= 1'b0;
      end else begin
         if (!(halt || haltReq)) begin
            pc <= nextPc;
         end
         if (haltReq) begin
            halt <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* rtl/decode/regFile.sv */
// Eight 16-bit registers, all cleared by reset
// Reads are combinational; a write lands at the edge, so a read
// in the same cycle sees the old value
`timescale 1ns/1ps
`default_nettype none

module regFile (
   input  logic            clk,
   input  logic            arstN,
   input  isaPkg::regIdx_t rdAddrA,
   input  isaPkg::regIdx_t rdAddrB,
   input  logic            we,
   input  isaPkg::regIdx_t wrAddr,
   input  isaPkg::word_t   wrData,
   output isaPkg::word_t   rdDataA,
   output isaPkg::word_t   rdDataB
);
   import isaPkg::*;

   word_t regs [2**REG_W];

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < 2**REG_W; i++) begin
            regs[i] <= '0;
         end
      end else if (we) begin
         regs[wrAddr] <= wrData;
      end
   end

   assign rdDataA = regs[rdAddrA];
   assign rdDataB = regs[rdAddrB];

endmodule

`default_nettype wire

/* rtl/decode/decode.sv */
// Opcode decoder and register file
// Unknown opcodes run as NOP with illegal set; err shows them
// Register writes and err stay low in reset and once halted
`timescale 1ns/1ps
`default_nettype none

module decode (
   input  logic              clk,
   input  logic              arstN,
   input  isaPkg::word_t     instr,
   input  logic              halted,
   input  isaPkg::word_t     wbData,
   output ctrlPkg::decoded_t dec,
   output isaPkg::regIdx_t   wrAddr,
   output logic              regWe,
   output logic              err
);
   import isaPkg::*;
   import ctrlPkg::*;

   opcode_e   op;
   aluFunct_e fn;
   regIdx_t   rsIdx;
   regIdx_t   rtIdx;
   word_t     rsVal;
   word_t     rtVal;
   word_t     sext5;
   word_t     zext5;
   word_t     sext8;
   word_t     sext11;
   ctrl_t     ctl;
   word_t     imm;
   regIdx_t   rd;
   logic      live;

   assign op    = opcode_e'(instr[OPC_LSB +: OPC_W]);
   assign fn    = aluFunct_e'(instr[FN_LSB +: FN_W]);
   assign rsIdx = instr[RS_LSB +: REG_W];
   // Rt position also holds the ST data register
   assign rtIdx = instr[RT_LSB +: REG_W];
   assign live  = arstN & ~halted;

   assign sext5  = {{(WORD_W-IMM5_W){instr[IMM5_W-1]}}, instr[IMM5_W-1:0]};
   assign zext5  = {{(WORD_W-IMM5_W){1'b0}}, instr[IMM5_W-1:0]};
   assign sext8  = {{(WORD_W-IMM8_W){instr[IMM8_W-1]}}, instr[IMM8_W-1:0]};
   assign sext11 = {{(WORD_W-DISP11_W){instr[DISP11_W-1]}}, instr[DISP11_W-1:0]};

   always_comb begin
      ctl        = '0;
      ctl.aluOp  = ALU_ADD;
      ctl.wbSel  = WB_ALU;
      ctl.pcSel  = PC_SEQ;
      ctl.brCond = BR_NONE;
      imm        = sext5;
      rd         = instr[RD_R_LSB +: REG_W];
      case (op)
         OP_HALT: ctl.halt = 1'b1;
         OP_NOP:  ;
         OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
            ctl.useImm = 1'b1;
            ctl.regWe  = 1'b1;
            rd         = instr[RD_I_LSB +: REG_W];
            case (op)
               OP_SUBI:  ctl.aluOp = ALU_SUB;
               OP_XORI:  ctl.aluOp = ALU_XOR;
               OP_ANDNI: ctl.aluOp = ALU_ANDN;
               default:  ctl.aluOp = ALU_ADD;
            endcase
            // Logical immediates are unsigned
            if (op == OP_XORI || op == OP_ANDNI) begin
               imm = zext5;
            end
         end
         OP_ALU: begin
            ctl.regWe = 1'b1;
            case (fn)
               FN_SUB:  ctl.aluOp = ALU_SUB;
               FN_XOR:  ctl.aluOp = ALU_XOR;
               FN_ANDN: ctl.aluOp = ALU_ANDN;
               default: ctl.aluOp = ALU_ADD;
            endcase
         end
         OP_LBI: begin
            ctl.aluOp  = ALU_PASSB;
            ctl.useImm = 1'b1;
            ctl.regWe  = 1'b1;
            imm        = sext8;
            rd         = rsIdx;
         end
         OP_LD: begin
            ctl.useImm = 1'b1;
            ctl.memRe  = 1'b1;
            ctl.wbSel  = WB_MEM;
            ctl.regWe  = 1'b1;
            rd         = instr[RD_I_LSB +: REG_W];
         end
         OP_ST: begin
            ctl.useImm = 1'b1;
            ctl.memWe  = 1'b1;
         end
         OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
            ctl.pcSel = PC_BRANCH;
            imm       = sext8;
            case (op)
               OP_BEQZ: ctl.brCond = BR_EQZ;
               OP_BNEZ: ctl.brCond = BR_NEZ;
               OP_BLTZ: ctl.brCond = BR_LTZ;
               default: ctl.brCond = BR_GEZ;
            endcase
         end
         OP_J: begin
            ctl.pcSel = PC_JUMP;
            imm       = sext11;
         end
         OP_JAL: begin
            ctl.pcSel = PC_JUMP;
            ctl.wbSel = WB_PC2;
            ctl.regWe = 1'b1;
            imm       = sext11;
            rd        = LINK_REG;
         end
         OP_JR: begin
            ctl.pcSel = PC_REG;
            imm       = sext8;
         end
         default: ctl.illegal = 1'b1;
      endcase
      ctl.regWe = ctl.regWe & live;
   end

   regFile u_regFile (
      .clk     (clk),
      .arstN   (arstN),
      .rdAddrA (rsIdx),
      .rdAddrB (rtIdx),
      .we      (ctl.regWe),
      .wrAddr  (rd),
      .wrData  (wbData),
      .rdDataA (rsVal),
      .rdDataB (rtVal)
   );

   assign dec    = '{ctrl: ctl, rsVal: rsVal, rtVal: rtVal, imm: imm, rd: rd};
   assign wrAddr = rd;
   assign regWe  = ctl.regWe;
   assign err    = ctl.illegal & live;

endmodule

`default_nettype wire

/* rtl/execute.sv */
// ALU and branch condition, purely combinational
// SUB and SUBI compute B minus A, that is Rt or imm minus Rs
`timescale 1ns/1ps
`default_nettype none

module execute (
   input  ctrlPkg::decoded_t dec,
   output isaPkg::word_t     aluRes,
   output logic              taken
);
   import isaPkg::*;
   import ctrlPkg::*;

   word_t opA;
   word_t opB;

   assign opA = dec.rsVal;
   // Memory ops take the offset through the immediate path
   assign opB = dec.ctrl.useImm ? dec.imm : dec.rtVal;

   always_comb begin
      case (dec.ctrl.aluOp)
         ALU_ADD:   aluRes = opA + opB;
         ALU_SUB:   aluRes = opB - opA;
         ALU_XOR:   aluRes = opA ^ opB;
         ALU_ANDN:  aluRes = opA & ~opB;
         ALU_PASSB: aluRes = opB;
         default:   aluRes = '0;
      endcase
   end

   // Conditions test Rs only
   always_comb begin
      case (dec.ctrl.brCond)
         BR_EQZ:  taken = (dec.rsVal == '0);
         BR_NEZ:  taken = (dec.rsVal != '0);
         BR_LTZ:  taken = dec.rsVal[WORD_W-1];
         BR_GEZ:  taken = ~dec.rsVal[WORD_W-1];
         default: taken = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

/* rtl/memory.sv */
// Data memory, next-PC select and write-back select
// Data memory is word addressed by the low bits of aluRes
// No store is made in reset or once halted
`timescale 1ns/1ps
`default_nettype none

module memory #(
   parameter int DMEM_WORDS = 256
) (
   input  logic              clk,
   input  logic              arstN,
   input  ctrlPkg::decoded_t dec,
   input  isaPkg::word_t     aluRes,
   input  logic              taken,
   input  isaPkg::word_t     pcPlus2,
   input  logic              halted,
   output isaPkg::word_t     nextPc,
   output isaPkg::word_t     wbData,
   output logic              stWe,
   output isaPkg::word_t     stAddr,
   output isaPkg::word_t     stData
);
   import isaPkg::*;
   import ctrlPkg::*;

   localparam int DAW = $clog2(DMEM_WORDS);

   word_t           dmem [DMEM_WORDS];
   logic [DAW-1:0]  dIdx;
   word_t           rdData;

   assign dIdx   = aluRes[DAW-1:0];
   assign stWe   = dec.ctrl.memWe & arstN & ~halted;
   assign stAddr = aluRes;
   assign stData = dec.rtVal;
   assign rdData = dec.ctrl.memRe ? dmem[dIdx] : '0;

   always_ff @(posedge clk) begin
      if (stWe) begin
         dmem[dIdx] <= stData;
      end
   end

   always_comb begin
      case (dec.ctrl.pcSel)
         PC_BRANCH: nextPc = taken ? pcPlus2 + dec.imm : pcPlus2;
         PC_JUMP:   nextPc = pcPlus2 + dec.imm;
         PC_REG:    nextPc = dec.rsVal + dec.imm;
         default:   nextPc = pcPlus2;
      endcase
   end

   always_comb begin
      case (dec.ctrl.wbSel)
         WB_MEM:  wbData = rdData;
         WB_PC2:  wbData = pcPlus2;
         default: wbData = aluRes;
      endcase
   end

endmodule

`default_nettype wire

/* rtl/proc.sv */
// Single-cycle 16-bit core, one instruction retired per clock
// Trace ports show the current instruction; state updates at the next edge
// Nothing retires while reset is held or after HALT
`timescale 1ns/1ps
`default_nettype none

module proc #(
   parameter int IMEM_WORDS = 256,
   parameter int DMEM_WORDS = 256
) (
   input  logic            clk,
   input  logic            arstN,
   input  logic            progWe,
   input  isaPkg::word_t   progAddr,
   input  isaPkg::word_t   progData,
   output logic            retValid,
   output isaPkg::word_t   retPc,
   output logic            rfWe,
   output isaPkg::regIdx_t rfAddr,
   output isaPkg::word_t   rfData,
   output logic            stWe,
   output isaPkg::word_t   stAddr,
   output isaPkg::word_t   stData,
   output logic            halt,
   output logic            err
);
   import isaPkg::*;
   import ctrlPkg::*;

   word_t    pc;
   word_t    pcPlus2;
   word_t    instr;
   word_t    nextPc;
   word_t    aluRes;
   word_t    wbData;
   logic     taken;
   decoded_t dec;

   fetch #(.IMEM_WORDS(IMEM_WORDS)) u_fetch (
      .clk      (clk),
      .arstN    (arstN),
      .progWe   (progWe),
      .progAddr (progAddr),
      .progData (progData),
      .nextPc   (nextPc),
      .haltReq  (dec.ctrl.halt),
      .pc       (pc),
      .pcPlus2  (pcPlus2),
      .instr    (instr),
      .halt     (halt)
   );

   decode u_decode (
      .clk    (clk),
      .arstN  (arstN),
      .instr  (instr),
      .halted (halt),
      .wbData (wbData),
      .dec    (dec),
      .wrAddr (rfAddr),
      .regWe  (rfWe),
      .err    (err)
   );

   execute u_execute (
      .dec    (dec),
      .aluRes (aluRes),
      .taken  (taken)
   );

   memory #(.DMEM_WORDS(DMEM_WORDS)) u_memory (
      .clk     (clk),
      .arstN   (arstN),
      .dec     (dec),
      .aluRes  (aluRes),
      .taken   (taken),
      .pcPlus2 (pcPlus2),
      .halted  (halt),
      .nextPc  (nextPc),
      .wbData  (wbData),
      .stWe    (stWe),
      .stAddr  (stAddr),
      .stData  (stData)
   );

   // Retire trace
   assign retValid = arstN & ~halt;
   assign retPc    = pc;
   assign rfData   = wbData;

endmodule

`default_nettype wire

/* test/clkGen.sv */
// Testbench clock and reset
// Reset is held while holdReset is high, then for RESET_CYCLES more edges
// arstN rises just after a rising edge, so that edge still sees reset
`timescale 1ns/1ps
`default_nettype none

module clkGen #(
   parameter int PERIOD       = 100,
   parameter int RESET_CYCLES = 16
) (
   input  logic holdReset,
   output logic clk,
   output logic arstN
);
   int resetCount = 0;

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   always @(posedge clk) begin
      if (holdReset) begin
         resetCount <= 0;
      end else if (resetCount < RESET_CYCLES) begin
         resetCount <= resetCount + 1;
      end
   end

   assign arstN = (resetCount == RESET_CYCLES);

endmodule

`default_nettype wire

/* test/proc_assertions.sv */
// Trace properties of proc, attached with bind
// Sampled on the rising edge, ignored while reset is held
`timescale 1ns/1ps
`default_nettype none

module proc_assertions (
   input logic clk,
   input logic arstN,
   input logic retValid,
   input logic rfWe,
   input logic stWe,
   input logic halt
);

   // No instruction both writes a register and stores
   noDualWrite: assert property (@(posedge clk) disable iff (!arstN) !(rfWe && stWe))
      else $error("Register write and store traced in the same cycle");

   // Once halted, nothing retires, writes a register or stores
   noRetireHalted: assert property (@(posedge clk) disable iff (!arstN)
      halt |-> !(retValid || rfWe || stWe))
      else $error("Retire, register write or store traced while halted");

   // Only reset clears halt
   haltSticky: assert property (@(posedge clk) disable iff (!arstN) halt |=> halt)
      else $error("Halt dropped without reset");

endmodule

`default_nettype wire

/* test/procTb.sv */
// Random-program testbench for proc, checked against an instruction-set model
// The program is loaded while reset is held, then the trace is compared
// with the model at every falling edge
// LD and ST use R5 as base, which the program never writes, so it stays zero
`timescale 1ns/1ps
`default_nettype none

module procTb;
   import isaPkg::*;

   localparam int PROG_WORDS = 200;
   localparam int BODY_START = 22;
   // LBI, ADD, ADD, JR, skipped word, HALT from here on
   localparam int BODY_END = 194;
   localparam int RESET_CYCLES = 16;
   localparam int MARGIN = 100;
   localparam int POST_HALT_CYCLES = 8;
   localparam int MAX_DIST = 12;
   // Load, reset, one cycle per instruction, then margin
   localparam int CYCLE_LIMIT = PROG_WORDS + RESET_CYCLES + PROG_WORDS + MARGIN;
   localparam regIdx_t BASE_REG = 3'd5;
   localparam logic [4:0] ILLEGAL_OPS [4] = '{5'b00010, 5'b00111, 5'b10100, 5'b11110};
   localparam opcode_e IMM_OPS [4] = '{OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI};
   localparam opcode_e BRANCH_OPS [4] = '{OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ};

   logic    clk;
   logic    arstN;
   logic    holdReset = 1'b1;
   logic    progWe = 1'b0;
   word_t   progAddr = '0;
   word_t   progData = '0;
   logic    retValid;
   word_t   retPc;
   logic    rfWe;
   regIdx_t rfAddr;
   word_t   rfData;
   logic    stWe;
   word_t   stAddr;
   word_t   stData;
   logic    halt;
   logic    err;

   word_t   prog [PROG_WORDS];
   int      loadIdx = 0;

   // Model state and the expected trace of the current instruction
   word_t   mPc = '0;
   word_t   mRegs [8];
   word_t   mMem [256];
   logic    mHalted = 1'b0;
   word_t   expPc;
   logic    expRfWe;
   regIdx_t expRfAddr;
   word_t   expRfData;
   logic    expStWe;
   word_t   expStAddr;
   word_t   expStData;
   logic    expErr;

   int valueErrs = 0;
   int otherErrs = 0;
   int cycleCount = 0;
   int postHalt = 0;

   clkGen #(.PERIOD(100), .RESET_CYCLES(RESET_CYCLES)) u_clkGen (
      .holdReset (holdReset),
      .clk       (clk),
      .arstN     (arstN)
   );

   proc #(.IMEM_WORDS(256), .DMEM_WORDS(256)) u_proc (
      .clk      (clk),
      .arstN    (arstN),
      .progWe   (progWe),
      .progAddr (progAddr),
      .progData (progData),
      .retValid (retValid),
      .retPc    (retPc),
      .rfWe     (rfWe),
      .rfAddr   (rfAddr),
      .rfData   (rfData),
      .stWe     (stWe),
      .stAddr   (stAddr),
      .stData   (stData),
      .halt     (halt),
      .err      (err)
   );

   bind proc proc_assertions u_procAssertions (
      .clk      (clk),
      .arstN    (arstN),
      .retValid (retValid),
      .rfWe     (rfWe),
      .stWe     (stWe),
      .halt     (halt)
   );

   function automatic word_t rFormat(aluFunct_e fn, regIdx_t rs, regIdx_t rt, regIdx_t rd);
      return {OP_ALU, rs, rt, rd, fn};
   endfunction

   function automatic word_t iFormat(opcode_e op, regIdx_t rs, regIdx_t rd, logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic word_t longFormat(opcode_e op, regIdx_t rs, logic [7:0] imm);
      return {op, rs, imm};
   endfunction

   function automatic word_t jumpFormat(opcode_e op, logic [10:0] disp);
      return {op, disp};
   endfunction

   function automatic regIdx_t randomReg();
      return regIdx_t'($urandom_range(0, 7));
   endfunction

   // Random results only go to R0..R4
   function automatic regIdx_t randomDest();
      return regIdx_t'($urandom_range(0, 4));
   endfunction

   task automatic buildProgram();
      int kind;
      int maxD;
      int d;
      // First instruction reads two registers straight out of reset
      prog[0] = rFormat(FN_XOR, 3'd6, 3'd7, 3'd0);
      for (int r = 0; r < 5; r++) begin
         prog[1 + r] = longFormat(OP_LBI, 3'(r), 8'($urandom_range(0, 255)));
      end
      // Fill every word that a later LD can reach
      for (int k = 0; k < 16; k++) begin
         prog[6 + k] = iFormat(OP_ST, BASE_REG, 3'(k % 5), 5'(k));
      end
      for (int i = BODY_START; i < BODY_END; i++) begin
         kind = $urandom_range(0, 99);
         maxD = BODY_END - (i + 1);
         d = (maxD >= 1) ? int'($urandom_range(1, (maxD < MAX_DIST) ? maxD : MAX_DIST)) : 0;
         if (kind < 25) begin
            prog[i] = rFormat(aluFunct_e'(2'($urandom_range(0, 3))), randomReg(), randomReg(),
                              randomDest());
         end else if (kind < 45) begin
            prog[i] = iFormat(IMM_OPS[2'($urandom_range(0, 3))], randomReg(), randomDest(),
                              5'($urandom_range(0, 31)));
         end else if (kind < 53) begin
            prog[i] = longFormat(OP_LBI, randomDest(), 8'($urandom_range(0, 255)));
         end else if (kind < 61) begin
            prog[i] = iFormat(OP_ST, BASE_REG, randomReg(), 5'($urandom_range(0, 15)));
         end else if (kind < 69) begin
            prog[i] = iFormat(OP_LD, BASE_REG, randomDest(), 5'($urandom_range(0, 15)));
         end else if (kind < 94 && d == 0) begin
            prog[i] = jumpFormat(OP_NOP, '0);
         end else if (kind < 85) begin
            prog[i] = longFormat(BRANCH_OPS[2'($urandom_range(0, 3))], randomReg(), 8'(2 * d));
         end else if (kind < 90) begin
            prog[i] = jumpFormat(OP_J, 11'(2 * d));
         end else if (kind < 94) begin
            prog[i] = jumpFormat(OP_JAL, 11'(2 * d));
         end else if (kind < 97) begin
            prog[i] = {ILLEGAL_OPS[2'($urandom_range(0, 3))], 11'($urandom_range(0, 2047))};
         end else begin
            prog[i] = jumpFormat(OP_NOP, '0);
         end
      end
      // R6 becomes 396 so JR lands on word 199 and skips word 198
      prog[BODY_END] = longFormat(OP_LBI, 3'd6, 8'd99);
      prog[BODY_END + 1] = rFormat(FN_ADD, 3'd6, 3'd6, 3'd6);
      prog[BODY_END + 2] = rFormat(FN_ADD, 3'd6, 3'd6, 3'd6);
      prog[BODY_END + 3] = longFormat(OP_JR, 3'd6, 8'd2);
      prog[BODY_END + 4] = {5'b11111, 11'd0};
      prog[BODY_END + 5] = jumpFormat(OP_HALT, '0);
   endtask

   // Executes one instruction on the model and records its trace
   task automatic stepModel();
      word_t      ins;
      logic [4:0] op;
      regIdx_t    rs;
      regIdx_t    rt;
      word_t      a;
      word_t      s5;
      word_t      z5;
      word_t      s8;
      word_t      s11;
      word_t      pc2;
      word_t      next;
      word_t      addr;
      ins = '0;
      if (int'(mPc[15:1]) < PROG_WORDS) begin
         ins = prog[mPc[8:1]];
      end else begin
         otherErrs++;
         $display("Model PC %h lies outside the program", mPc);
      end
      op = ins[15:11];
      rs = ins[10:8];
      rt = ins[7:5];
      a = mRegs[rs];
      s5 = {{11{ins[4]}}, ins[4:0]};
      z5 = {11'd0, ins[4:0]};
      s8 = {{8{ins[7]}}, ins[7:0]};
      s11 = {{5{ins[10]}}, ins[10:0]};
      pc2 = mPc + 16'd2;
      next = pc2;
      addr = a + s5;
      expPc = mPc;
      expRfWe = op inside {OP_ALU, OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI, OP_LBI, OP_LD, OP_JAL};
      expRfAddr = rt;
      expRfData = '0;
      expStWe = 1'b0;
      expStAddr = addr;
      expStData = mRegs[rt];
      expErr = 1'b0;
      case (op)
         OP_ALU: begin
            expRfAddr = ins[4:2];
            case (ins[1:0])
               FN_ADD:  expRfData = a + mRegs[rt];
               FN_SUB:  expRfData = mRegs[rt] - a;
               FN_XOR:  expRfData = a ^ mRegs[rt];
               default: expRfData = a & ~mRegs[rt];
            endcase
         end
         OP_ADDI:  expRfData = a + s5;
         OP_SUBI:  expRfData = s5 - a;
         OP_XORI:  expRfData = a ^ z5;
         OP_ANDNI: expRfData = a & ~z5;
         OP_LBI: begin
            expRfAddr = rs;
            expRfData = s8;
         end
         OP_LD:    expRfData = mMem[addr[7:0]];
         OP_ST:    expStWe = 1'b1;
         OP_BEQZ:  next = (a == '0) ? pc2 + s8 : pc2;
         OP_BNEZ:  next = (a != '0) ? pc2 + s8 : pc2;
         OP_BLTZ:  next = a[15] ? pc2 + s8 : pc2;
         OP_BGEZ:  next = !a[15] ? pc2 + s8 : pc2;
         OP_J:     next = pc2 + s11;
         OP_JAL: begin
            expRfAddr = 3'd7;
            expRfData = pc2;
            next = pc2 + s11;
         end
         OP_JR:    next = a + s8;
         OP_NOP:   ;
         OP_HALT:  mHalted = 1'b1;
         default:  expErr = 1'b1;
      endcase
      if (expRfWe) begin
         mRegs[expRfAddr] = expRfData;
      end
      if (expStWe) begin
         mMem[addr[7:0]] = expStData;
      end
      if (!mHalted) begin
         mPc = next;
      end
   endtask

   task automatic checkWord(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         valueErrs++;
         $display("Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic checkIdx(input string name, input regIdx_t exp, input regIdx_t act);
      if (act !== exp) begin
         valueErrs++;
         $display("Error %s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   task automatic checkBit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         valueErrs++;
         $display("Error %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic checkCycle();
      string tag;
      if (mHalted) begin
         tag = "after HALT";
         checkBit({tag, " retValid"}, 1'b0, retValid);
         checkBit({tag, " rfWe"}, 1'b0, rfWe);
         checkBit({tag, " stWe"}, 1'b0, stWe);
         checkBit({tag, " err"}, 1'b0, err);
         checkBit({tag, " halt"}, 1'b1, halt);
         postHalt++;
      end else begin
         tag = $sformatf("pc %h", mPc);
         stepModel();
         checkBit({tag, " retValid"}, 1'b1, retValid);
         checkWord({tag, " retPc"}, expPc, retPc);
         checkBit({tag, " halt"}, 1'b0, halt);
         checkBit({tag, " err"}, expErr, err);
         checkBit({tag, " rfWe"}, expRfWe, rfWe);
         if (expRfWe) begin
            checkIdx({tag, " rfAddr"}, expRfAddr, rfAddr);
            checkWord({tag, " rfData"}, expRfData, rfData);
         end
         checkBit({tag, " stWe"}, expStWe, stWe);
         if (expStWe) begin
            checkWord({tag, " stAddr"}, expStAddr, stAddr);
            checkWord({tag, " stData"}, expStData, stData);
         end
      end
   endtask

   task automatic reportAndFinish();
      $display("Value errors: %0d, other errors: %0d", valueErrs, otherErrs);
      if (valueErrs == 0 && otherErrs == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   endtask

   initial begin
      void'($urandom(32'hafb0));
      for (int r = 0; r < 8; r++) begin
         mRegs[r] = '0;
      end
      for (int m = 0; m < 256; m++) begin
         mMem[m] = '0;
      end
      buildProgram();
   end

   // One word per edge, then reset is let go
   always @(posedge clk) begin
      if (loadIdx < PROG_WORDS) begin
         progWe <= 1'b1;
         progAddr <= word_t'(loadIdx);
         progData <= prog[loadIdx];
         loadIdx <= loadIdx + 1;
      end else begin
         progWe <= 1'b0;
         holdReset <= 1'b0;
      end
   end

   always @(negedge clk) begin
      cycleCount++;
      if (cycleCount > CYCLE_LIMIT) begin
         otherErrs++;
         $display("Timeout: the program did not finish within %0d cycles", CYCLE_LIMIT);
         reportAndFinish();
      end else if (arstN) begin
         checkCycle();
         if (postHalt == POST_HALT_CYCLES) begin
            reportAndFinish();
         end
      end else begin
         // Trace stays quiet while reset is held
         checkBit("in reset retValid", 1'b0, retValid);
         checkBit("in reset rfWe", 1'b0, rfWe);
      end
   end

endmodule

`default_nettype wire

/* build.f */
common/isaPkg.sv
common/ctrlPkg.sv
rtl/fetch.sv
rtl/decode/regFile.sv
rtl/decode/decode.sv
rtl/execute.sv
rtl/memory.sv
rtl/proc.sv
test/clkGen.sv
test/proc_assertions.sv
test/procTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the proc testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -j 0 \
   --top-module procTb -f build.f -o procSim

out=$(./obj_dir/procSim || true)
echo "$out"

if echo "$out" | grep -qx "All checks passed"; then
   exit 0
else
   exit 1
fi
